/* flist.f */
design/fmulPkg.sv
design/fmulProducer.sv
design/resultRingBuffer.sv
design/writebackStage.sv
design/fmulUnitTop.sv
verification/fmulAssert_assert.sv
verification/fmulTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the multiply lane testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -f flist.f --top-module fmulTb \
	-Mdir "$BUILD_DIR" -o fmulSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/fmulSim" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"

if grep -q "TESTBENCH FAILED" "$LOG_FILE"; then
	echo "simulation reported a failure, see $LOG_FILE"
	exit 1
fi

if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

exit 0

/* verification/fmulTb.sv */
// Testbench for the float multiply lane that runs as top module fmulTb through flist.f and run.sh.
`timescale 1ns/1ps

module fmulTb
	import fmulPkg::*;
;

	localparam int numNormal   = 5;
	localparam int numSpecial  = 7;
	localparam int numRandom   = 200;
	localparam int totalIssues = numNormal * 4 + numSpecial + 2 + numRandom + pipeDepth;
	localparam int drainLimit  = 4 * pipeDepth + 16;

	logic                  clock;
	logic                  reset;
	logic                  issueEnable;
	opcode_t               opcode;
	floatWord_t            operandA;
	floatWord_t            operandB;
	logic [indexWidth-1:0] destIndex;
	logic [issueWidth-1:0] issueNo;
	logic                  stall;
	logic                  ready;
	logic                  writeEnable;
	floatWord_t            writeData;
	logic [indexWidth-1:0] writeIndex;
	logic [issueWidth-1:0] writeIssueNo;
	logic                  overflowFlag;

	// scoreboard queues hold one entry per accepted issue
	logic [31:0]           expData  [$];
	logic [indexWidth-1:0] expIndex [$];
	logic [issueWidth-1:0] expIssue [$];
	logic                  expOvf   [$];
	logic [issueWidth-1:0] nextIssueNo;
	logic                  stickyWant;
	logic [31:0]           wantData;
	logic                  wantOvf;

	logic [31:0] normalA  [numNormal]  = '{32'h3FC00000, 32'hC0500000, 32'h3F800000,
		32'h40490FDB, 32'h5F000000};
	logic [31:0] normalB  [numNormal]  = '{32'h40000000, 32'h3DCCCCCD, 32'hBF800000,
		32'h402DF854, 32'h20000000};
	logic [31:0] specialA [numSpecial] = '{32'h00000000, 32'h80000000, 32'h00400000,
		32'h7F800000, 32'h7FC00000, 32'h00000000, 32'h00800000};
	logic [31:0] specialB [numSpecial] = '{32'h3F800000, 32'h40000000, 32'h40000000,
		32'hBF800000, 32'h3F800000, 32'h7F800000, 32'h00800000};

	fmulUnitTop uut (
		.clock(clock), .reset(reset), .issueEnable(issueEnable), .opcode(opcode),
		.operandA(operandA), .operandB(operandB), .destIndex(destIndex),
		.issueNo(issueNo), .stall(stall), .ready(ready), .writeEnable(writeEnable),
		.writeData(writeData), .writeIndex(writeIndex), .writeIssueNo(writeIssueNo),
		.overflowFlag(overflowFlag)
	);

	always #2 clock = ~clock; // 4 ns period

	// ========================================================================
	// reference model and helpers
	// ========================================================================

	// returns {overflow, result word}
	function automatic logic [32:0] refMultiply(input opcode_t op, input floatWord_t a,
		input floatWord_t b);
		floatWord_t  y;
		floatWord_t  r;
		logic [47:0] mant;
		logic [22:0] frac;
		logic        ovf;
		int          e;
		y = (op == opSquare) ? a : b;
		r.raw = 32'd0;
		ovf = 1'b0;
		if (a.fields.exponent == 8'd0 || y.fields.exponent == 8'd0) begin
			r.fields.exponent = 8'd0;
		end else if (a.fields.exponent == 8'hFF || y.fields.exponent == 8'hFF) begin
			r.fields.exponent = 8'hFF;
		end else begin
			mant = 48'({1'b1, a.fields.fraction}) * 48'({1'b1, y.fields.fraction});
			e = int'(a.fields.exponent) + int'(y.fields.exponent) - expBias;
			if (mant[47]) begin
				e = e + 1;
				frac = mant[46:24];
			end else begin
				frac = mant[45:23];
			end
			if (e >= 255) begin
				r.fields.exponent = 8'hFF;
				ovf = 1'b1;
			end else if (e > 0) begin
				r.fields.exponent = e[7:0];
				r.fields.fraction = frac;
			end
		end
		case (op)
			opNegMul: r.fields.sign = ~(a.fields.sign ^ y.fields.sign);
			opAbsMul: r.fields.sign = 1'b0;
			default:  r.fields.sign = a.fields.sign ^ y.fields.sign;
		endcase
		return {ovf, r.raw};
	endfunction

	task automatic stopWithFailure(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			stopWithFailure($sformatf("FAILED %s got 0x%h expected 0x%h", name, actual,
				expected));
		end
	endtask

	task automatic waitForReady();
		int waited;
		waited = 0;
		while (!ready) begin
			stall = 1'b0; // let the buffer drain
			if (waited > drainLimit) stopWithFailure("ready stayed low with stall released");
			@(posedge clock);
			#1;
			waited++;
		end
	endtask

	task automatic issueOne(input opcode_t op, input logic [31:0] a, input logic [31:0] b);
		logic [31:0] rnd;
		logic [32:0] expected;
		rnd = $urandom;
		waitForReady();
		opcode = op;
		operandA.raw = a;
		operandB.raw = b;
		destIndex = rnd[indexWidth-1:0];
		issueNo = nextIssueNo;
		issueEnable = 1'b1;
		expected = refMultiply(op, operandA, operandB);
		expData.push_back(expected[31:0]);
		expOvf.push_back(expected[32]);
		expIndex.push_back(rnd[indexWidth-1:0]);
		expIssue.push_back(nextIssueNo);
		nextIssueNo = nextIssueNo + 1'b1;
		@(posedge clock);
		#1;
		issueEnable = 1'b0;
	endtask

	task automatic waitDrained();
		int waited;
		waited = 0;
		stall = 1'b0;
		while (expData.size() != 0) begin
			if (waited > drainLimit) stopWithFailure("results still pending after drain time");
			@(posedge clock);
			#1;
			waited++;
		end
		repeat (4) @(posedge clock); // a duplicate write would hit the empty queue
		#1;
	endtask

	// ========================================================================
	// scoreboard compare
	// ========================================================================

	always @(negedge clock) begin
		if (!reset && writeEnable) begin
			if (expData.size() == 0) begin
				stopWithFailure("write port fired with no result pending");
			end else begin
				wantData = expData.pop_front();
				wantOvf = expOvf.pop_front();
				stickyWant = stickyWant | wantOvf;
				checkValue("writeData", writeData.raw, wantData);
				checkValue("writeIndex", 32'(writeIndex), 32'(expIndex.pop_front()));
				checkValue("writeIssueNo", 32'(writeIssueNo), 32'(expIssue.pop_front()));
				checkValue("overflowFlag", 32'(overflowFlag), 32'(stickyWant));
			end
		end
	end

	initial begin
		repeat (totalIssues * 20) @(posedge clock);
		stopWithFailure("timeout, the run took longer than its test length allows");
	end

	// ========================================================================
	// stimulus
	// ========================================================================

	initial begin
		logic [31:0] rnd;
		logic [31:0] rndA;
		logic [31:0] rndB;
		int          latency;
		int          accepted;
		rnd = $urandom(32'h0650_b18a);
		clock = 1'b0;
		reset = 1'b1;
		issueEnable = 1'b0;
		opcode = opMul;
		operandA.raw = 32'd0;
		operandB.raw = 32'd0;
		destIndex = '0;
		issueNo = '0;
		stall = 1'b0;
		nextIssueNo = '0;
		stickyWant = 1'b0;
		repeat (4) @(posedge clock);
		#1;
		reset = 1'b0;
		checkValue("ready", 32'(ready), 32'd1);
		checkValue("writeEnable", 32'(writeEnable), 32'd0);
		checkValue("overflowFlag", 32'(overflowFlag), 32'd0);

		// normal products under every opcode with a random operand two for square
		for (int op = 0; op < 4; op++) begin
			for (int k = 0; k < numNormal; k++) begin
				rnd = $urandom;
				issueOne(opcode_t'(op[1:0]), normalA[k], (op == 3) ? rnd : normalB[k]);
			end
		end
		waitDrained();
		checkValue("overflowFlag", 32'(overflowFlag), 32'd0);

		for (int k = 0; k < numSpecial; k++) begin
			issueOne(opMul, specialA[k], specialB[k]);
		end
		issueOne(opMul, 32'h7F000000, 32'h7F000000); // exponent saturates
		waitDrained();
		checkValue("overflowFlag", 32'(overflowFlag), 32'd1);

		// single issue into an idle lane
		issueOne(opMul, 32'h3F800000, 32'h40400000);
		latency = 1;
		while (!writeEnable) begin
			if (latency > 10) stopWithFailure("no write after a single issue");
			@(posedge clock);
			#1;
			latency++;
		end
		checkValue("writeLatency", latency, 32'd3);
		waitDrained();

		for (int i = 0; i < numRandom; i++) begin
			rnd = $urandom;
			stall = (rnd[1:0] == 2'd0);
			if (rnd[4:2] == 3'd0) begin
				@(posedge clock); // idle gap
				#1;
			end
			rndA = $urandom;
			rndB = $urandom;
			issueOne(opcode_t'(rnd[6:5]), rndA, rndB);
		end
		waitDrained();

		// fill under stall while one item rides in the producer register
		stall = 1'b1;
		accepted = 0;
		while (ready && accepted <= pipeDepth) begin
			rndA = $urandom;
			rndB = $urandom;
			issueOne(opMul, rndA, rndB);
			accepted++;
		end
		checkValue("acceptedWhileStalled", accepted, 32'(pipeDepth));
		repeat (3) begin
			@(posedge clock);
			#1;
			checkValue("ready", 32'(ready), 32'd0);
			checkValue("writeEnable", 32'(writeEnable), 32'd0);
		end
		waitDrained();
		checkValue("overflowFlag", 32'(overflowFlag), 32'd1);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* verification/fmulAssert_assert.sv */
// Protocol checks on the multiply lane top level, bound into every fmulUnitTop instance.
`timescale 1ns/1ps

module fmulAssert (
	input logic clock,
	input logic reset,
	input logic issueEnable,
	input logic ready,
	input logic stall,
	input logic writeEnable
);

	// ========================================================================
	// lane protocol
	// ========================================================================

	issueNeedsReady: assert property (@(posedge clock) disable iff (reset)
		issueEnable |-> ready)
		else $error("issueEnable asserted while ready was low");

	quietInReset: assert property (@(posedge clock)
		reset |=> !writeEnable)
		else $error("writeEnable high right after a reset cycle");

	// a stalled buffer pops nothing, so nothing reaches the write port
	noWriteAfterStall: assert property (@(posedge clock) disable iff (reset)
		stall |=> !writeEnable)
		else $error("writeEnable rose one cycle after stall was high");

endmodule

bind fmulUnitTop fmulAssert assertChecks (
	.clock(clock), .reset(reset), .issueEnable(issueEnable),
	.ready(ready), .stall(stall), .writeEnable(writeEnable)
);

/* design/fmulUnitTop.sv */
// Top of the float multiply lane, chaining producer, result ring buffer and writeback.
`timescale 1ns/1ps

module fmulUnitTop
	import fmulPkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  issueEnable,
	input  opcode_t               opcode,
	input  floatWord_t            operandA,
	input  floatWord_t            operandB,
	input  logic [indexWidth-1:0] destIndex,
	input  logic [issueWidth-1:0] issueNo,
	input  logic                  stall,
	output logic                  ready,
	output logic                  writeEnable,
	output floatWord_t            writeData,
	output logic [indexWidth-1:0] writeIndex,
	output logic [issueWidth-1:0] writeIssueNo,
	output logic                  overflowFlag
);

	// producer to buffer
	logic                  productValid;
	floatWord_t            productData;
	logic [indexWidth-1:0] productIndex;
	logic [issueWidth-1:0] productIssueNo;
	logic                  productOverflow;

	// buffer to writeback
	logic                  readValid;
	floatWord_t            readData;
	logic [indexWidth-1:0] readIndex;
	logic [issueWidth-1:0] readIssueNo;
	logic                  readOverflow;

	// ========================================================================
	// lane stages
	// ========================================================================

	fmulProducer producer (
		.clock(clock), .reset(reset),
		.issueEnable(issueEnable), .opcode(opcode),
		.operandA(operandA), .operandB(operandB),
		.destIndex(destIndex), .issueNo(issueNo),
		.productValid(productValid), .productData(productData),
		.productIndex(productIndex), .productIssueNo(productIssueNo),
		.productOverflow(productOverflow)
	);

	resultRingBuffer #(.numEntries(pipeDepth)) ringBuffer (
		.clock(clock), .reset(reset),
		.writeValid(productValid), .writeData(productData),
		.writeIndex(productIndex), .writeIssueNo(productIssueNo),
		.writeOverflow(productOverflow), .stall(stall),
		.readValid(readValid), .readData(readData), .readIndex(readIndex),
		.readIssueNo(readIssueNo), .readOverflow(readOverflow), .ready(ready)
	);

	writebackStage writeback (
		.clock(clock), .reset(reset),
		.resultValid(readValid), .resultData(readData), .resultIndex(readIndex),
		.resultIssueNo(readIssueNo), .resultOverflow(readOverflow),
		.writeEnable(writeEnable), .writeData(writeData), .writeIndex(writeIndex),
		.writeIssueNo(writeIssueNo), .overflowFlag(overflowFlag)
	);

endmodule

/* design/writebackStage.sv */
// Registers each drained result onto the register file write port and keeps a sticky overflow flag.
`timescale 1ns/1ps

module writebackStage
	import fmulPkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  resultValid,
	input  floatWord_t            resultData,
	input  logic [indexWidth-1:0] resultIndex,
	input  logic [issueWidth-1:0] resultIssueNo,
	input  logic                  resultOverflow,
	output logic                  writeEnable,
	output floatWord_t            writeData,
	output logic [indexWidth-1:0] writeIndex,
	output logic [issueWidth-1:0] writeIssueNo,
	output logic                  overflowFlag
);

	// ========================================================================
	// control
	// ========================================================================

	always_ff @(posedge clock) begin
		if (reset) begin
			writeEnable  <= 1'b0;
			overflowFlag <= 1'b0;
		end else begin
			writeEnable <= resultValid;
			if (resultValid && resultOverflow) begin
				overflowFlag <= 1'b1; // held until reset
			end
		end
	end

	// ========================================================================
	// write port payload
	// ========================================================================

	always_ff @(posedge clock) begin
		if (resultValid) begin
			writeData    <= resultData;
			writeIndex   <= resultIndex;
			writeIssueNo <= resultIssueNo;
		end
	end

endmodule

/* design/resultRingBuffer.sv */
// Queues registered products in a wrapping ring and pops the head whenever stall is low.
`timescale 1ns/1ps

module resultRingBuffer
	import fmulPkg::*;
#(
	parameter int numEntries = pipeDepth
)(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  writeValid,
	input  floatWord_t            writeData,
	input  logic [indexWidth-1:0] writeIndex,
	input  logic [issueWidth-1:0] writeIssueNo,
	input  logic                  writeOverflow,
	input  logic                  stall,
	output logic                  readValid,
	output floatWord_t            readData,
	output logic [indexWidth-1:0] readIndex,
	output logic [issueWidth-1:0] readIssueNo,
	output logic                  readOverflow,
	output logic                  ready
);

	localparam int ptrWidth   = $clog2(numEntries);
	localparam int countWidth = $clog2(numEntries + 1);

	floatWord_t            dataMem     [numEntries];
	logic [indexWidth-1:0] indexMem    [numEntries];
	logic [issueWidth-1:0] issueMem    [numEntries];
	logic                  overflowMem [numEntries];

	logic [ptrWidth-1:0]   writePtr;
	logic [ptrWidth-1:0]   readPtr;
	logic [countWidth-1:0] count;

	// ========================================================================
	// head and flow control
	// ========================================================================

	assign readValid    = (count != '0) && !stall;               // pop this cycle
	assign ready        = count <= countWidth'(numEntries - 2);  // one slot kept for producer reg
	assign readData     = dataMem[readPtr];
	assign readIndex    = indexMem[readPtr];
	assign readIssueNo  = issueMem[readPtr];
	assign readOverflow = overflowMem[readPtr];

	always_ff @(posedge clock) begin
		if (writeValid) begin
			dataMem[writePtr]     <= writeData;
			indexMem[writePtr]    <= writeIndex;
			issueMem[writePtr]    <= writeIssueNo;
			overflowMem[writePtr] <= writeOverflow;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			writePtr <= '0;
			readPtr  <= '0;
			count    <= '0;
		end else begin
			if (writeValid) begin
				writePtr <= (writePtr == ptrWidth'(numEntries - 1)) ? '0 : writePtr + 1'b1;
			end
			if (readValid) begin
				readPtr <= (readPtr == ptrWidth'(numEntries - 1)) ? '0 : readPtr + 1'b1;
			end
			case ({writeValid, readValid})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // idle or push with pop
			endcase
		end
	end

endmodule

/* design/fmulProducer.sv */
// Decodes the opcode and registers one truncated float product per issue strobe, one cycle later.
`timescale 1ns/1ps

module fmulProducer
	import fmulPkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  issueEnable,
	input  opcode_t               opcode,
	input  floatWord_t            operandA,
	input  floatWord_t            operandB,
	input  logic [indexWidth-1:0] destIndex,
	input  logic [issueWidth-1:0] issueNo,
	output logic                  productValid,
	output floatWord_t            productData,
	output logic [indexWidth-1:0] productIndex,
	output logic [issueWidth-1:0] productIssueNo,
	output logic                  productOverflow
);

	floatWord_t        srcA;
	floatWord_t        srcB;
	floatWord_t        resultWord;
	logic              rawSign;
	logic              resultOverflow;
	logic [47:0]       mantProduct;
	logic signed [9:0] expSum;
	logic signed [9:0] expFinal;

	// ========================================================================
	// operand select and datapath
	// ========================================================================

	assign srcA = operandA;
	assign srcB = (opcode == opSquare) ? operandA : operandB; // square ignores operand two

	assign mantProduct = {1'b1, srcA.fields.fraction} * {1'b1, srcB.fields.fraction};
	assign expSum      = $signed({2'b00, srcA.fields.exponent})
	                   + $signed({2'b00, srcB.fields.exponent}) - 10'(expBias);
	assign expFinal    = expSum + $signed({9'd0, mantProduct[47]}); // normalize carry
	assign rawSign     = srcA.fields.sign ^ srcB.fields.sign;

	always_comb begin
		resultWord.raw = '0;
		resultOverflow = 1'b0;
		if (srcA.fields.exponent == 8'd0 || srcB.fields.exponent == 8'd0) begin
			resultWord.fields.exponent = 8'd0; // zero operand wins
		end else if (srcA.fields.exponent == 8'hFF || srcB.fields.exponent == 8'hFF) begin
			resultWord.fields.exponent = 8'hFF; // inf in, inf out, NaN folded in
		end else if (expFinal <= 10'sd0) begin
			resultWord.fields.exponent = 8'd0; // underflow flushes to zero
		end else if (expFinal >= 10'sd255) begin
			resultWord.fields.exponent = 8'hFF; // saturate to infinity
			resultOverflow = 1'b1;
		end else begin
			resultWord.fields.exponent = expFinal[7:0];
			// truncate below the leading one
			if (mantProduct[47]) begin
				resultWord.fields.fraction = mantProduct[46:24];
			end else begin
				resultWord.fields.fraction = mantProduct[45:23];
			end
		end

		// opcode sign treatment on the raw product
		case (opcode)
			opNegMul: resultWord.fields.sign = ~rawSign;
			opAbsMul: resultWord.fields.sign = 1'b0;
			default:  resultWord.fields.sign = rawSign; // mul, square
		endcase
	end

	// ========================================================================
	// output register
	// ========================================================================

	always_ff @(posedge clock) begin
		if (reset) begin
			productValid <= 1'b0;
		end else begin
			productValid <= issueEnable;
		end
	end

	always_ff @(posedge clock) begin
		if (issueEnable) begin
			productData.raw <= resultWord.raw;
			productIndex    <= destIndex;
			productIssueNo  <= issueNo;
			productOverflow <= resultOverflow;
		end
	end

endmodule

/* design/fmulPkg.sv */
// Shared opcode, float word view and sizing constants, imported by every block of the multiply lane.

package fmulPkg;

	// ========================================================================
	// sizing
	// ========================================================================

	localparam int indexWidth = 5;   // register file destination index
	localparam int issueWidth = 4;   // issue tag carried with each result
	localparam int pipeDepth  = 8;   // ring buffer entries
	localparam int expBias    = 127; // single precision bias

	// ========================================================================
	// types
	// ========================================================================

	typedef enum logic [1:0] {
		opMul    = 2'd0, // plain product
		opNegMul = 2'd1, // product, sign inverted
		opAbsMul = 2'd2, // product, sign cleared
		opSquare = 2'd3  // operand one squared
	} opcode_t;

	// the same 32 bits seen as a bus word or as IEEE fields
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic        sign;
			logic [7:0]  exponent;
			logic [22:0] fraction;
		} fields;
	} floatWord_t;

endpackage
